// ==== common/memStage_config.svh ====
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// Address and data word width
`define ADDR_W 32

// One cache block is 16 words
`define BLOCK_BITS 512

// Byte offset inside a block; the upper 4 bits pick the word
`define OFFSET_W 6

// Direct-mapped cache geometry
`define LINES 16
`define INDEX_W 4

// Whatever is left of the address above index and offset
`define TAG_W 22

// Host memory depth in blocks, higher block addresses wrap
`define HOST_BLOCKS 64

`endif

// ==== common/memPkg.sv ====
`default_nettype none

`include "memStage_config.svh"

package memPkg;

    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [`OFFSET_W-3:0] wordSel;
        logic [1:0]           byteOff;
    } addrFieldsT;

    // The same word seen either as a plain address or split into cache fields
    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        addrFieldsT         f;
    } memAddrT;

    typedef logic [`BLOCK_BITS-1:0] blockT;

    typedef struct packed {
        logic               read;
        logic               write;
        memAddrT            addr;
        logic [`ADDR_W-1:0] wdata;
    } cpuReqT;

    typedef struct packed {
        logic [`ADDR_W-1:0] rdata;
    } cpuRspT;

    typedef enum logic {
        HOST_FILL,
        HOST_WRITEBACK
    } hostOpT;

    typedef struct packed {
        hostOpT                       op;
        logic [`TAG_W+`INDEX_W-1:0]   blockAddr;
        blockT                        wblock;
    } hostReqT;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITEBACK,
        FILL,
        RELEASE,
        DONE_WAIT
    } ctrlStateT;

endpackage

`default_nettype wire

// ==== memoryStage/dataCache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module dataCache (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire memPkg::memAddrT     addr,
    input  wire logic [`ADDR_W-1:0]  wdata,
    input  wire logic                writeWord,
    input  wire logic                loadBlock,
    input  wire memPkg::blockT       fillBlock,
    output logic                     hit,
    output logic                     dirty,
    output logic [`TAG_W-1:0]        victimTag,
    output logic [`ADDR_W-1:0]       rdata,
    output memPkg::blockT            victimBlock
);

    import memPkg::*;

    logic [`LINES-1:0]    lineValid;
    logic [`LINES-1:0]    lineDirty;
    logic [`TAG_W-1:0]    tagArr [`LINES];
    blockT                dataArr [`LINES];

    logic [`INDEX_W-1:0]  idx;
    logic [`OFFSET_W-3:0] wordSel;

    assign idx     = addr.f.index;
    assign wordSel = addr.f.wordSel;

    // Everything below reads the line picked by the current address
    assign hit         = lineValid[idx] && (tagArr[idx] == addr.f.tag);
    assign dirty       = lineDirty[idx];
    assign victimTag   = tagArr[idx];
    assign victimBlock = dataArr[idx];
    assign rdata       = dataArr[idx][wordSel*`ADDR_W +: `ADDR_W];

    // Block storage and tags
    always_ff @(posedge clk) begin
        if (loadBlock) begin
            dataArr[idx] <= fillBlock;
            tagArr[idx]  <= addr.f.tag;
        end else if (writeWord) begin
            dataArr[idx][wordSel*`ADDR_W +: `ADDR_W] <= wdata;
        end
    end

    // A refill brings in a clean copy, a store marks the line as modified
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lineValid <= '0;
            lineDirty <= '0;
        end else if (loadBlock) begin
            lineValid[idx] <= 1'b1;
            lineDirty[idx] <= 1'b0;
        end else if (writeWord) begin
            lineDirty[idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== memoryStage/dCacheController.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module dCacheController (
    input  wire logic                        clk,
    input  wire logic                        arstN,
    input  wire memPkg::cpuReqT              cpuReq,
    input  wire logic                        cpuReqValid,
    input  wire logic                        hit,
    input  wire logic                        dirty,
    input  wire logic [`TAG_W-1:0]           victimTag,
    input  wire logic                        hostAck,
    output logic                             cpuAck,
    output logic                             hostReqValid,
    output memPkg::hostOpT                   hostOp,
    output logic [`TAG_W+`INDEX_W-1:0]       hostBlockAddr,
    output logic                             writeWord,
    output logic                             loadBlock,
    output logic                             stallDma
);

    import memPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    hostOpT    opReg;
    hostOpT    opNext;
    logic      cpuAckNext;
    logic      accessReq;

    // A request with neither read nor write set is simply acknowledged
    assign accessReq = cpuReq.read | cpuReq.write;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= IDLE;
            opReg  <= HOST_FILL;
            cpuAck <= 1'b0;
        end else begin
            state  <= nextState;
            opReg  <= opNext;
            cpuAck <= cpuAckNext;
        end
    end

    always_comb begin
        nextState  = state;
        opNext     = opReg;
        cpuAckNext = cpuAck;
        case (state)
            IDLE: begin
                if (cpuReqValid) begin
                    nextState = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit || !accessReq) begin
                    nextState = RESPOND;
                end else if (dirty) begin
                    // The victim must reach host memory before its line is reused
                    nextState = WRITEBACK;
                    opNext    = HOST_WRITEBACK;
                end else begin
                    nextState = FILL;
                    opNext    = HOST_FILL;
                end
            end
            RESPOND: begin
                nextState  = DONE_WAIT;
                cpuAckNext = 1'b1;
            end
            WRITEBACK, FILL: begin
                if (hostAck) begin
                    nextState = RELEASE;
                end
            end
            RELEASE: begin
                // Wait for the host to drop its ack before the next phase
                if (!hostAck) begin
                    if (opReg == HOST_WRITEBACK) begin
                        nextState = FILL;
                        opNext    = HOST_FILL;
                    end else begin
                        nextState = LOOKUP;
                    end
                end
            end
            DONE_WAIT: begin
                if (!cpuReqValid) begin
                    nextState  = IDLE;
                    cpuAckNext = 1'b0;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    assign hostReqValid = (state == WRITEBACK) || (state == FILL);
    assign stallDma     = (state == WRITEBACK) || (state == FILL) || (state == RELEASE);
    assign hostOp       = opReg;

    // Write-back goes to where the victim came from, a fill to the requested block
    assign hostBlockAddr = (opReg == HOST_WRITEBACK) ?
                           {victimTag, cpuReq.addr.f.index} :
                           {cpuReq.addr.f.tag, cpuReq.addr.f.index};

    // Stores update the cache only once the line is known to hit
    assign writeWord = (state == RESPOND) && cpuReq.write;
    assign loadBlock = (state == FILL) && hostAck;

endmodule

`default_nettype wire

// ==== memoryStage/memoryStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module memoryStage (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire memPkg::cpuReqT   cpuReq,
    input  wire logic             cpuReqValid,
    input  wire memPkg::blockT    hostRsp,
    input  wire logic             hostAck,
    output memPkg::cpuRspT        cpuRsp,
    output logic                  cpuAck,
    output memPkg::hostReqT       hostReq,
    output logic                  hostReqValid,
    output logic                  stallDma
);

    import memPkg::*;

    logic                         hit;
    logic                         dirty;
    logic                         writeWord;
    logic                         loadBlock;
    logic [`TAG_W-1:0]            victimTag;
    logic [`ADDR_W-1:0]           rdata;
    blockT                        victimBlock;
    hostOpT                       hostOp;
    logic [`TAG_W+`INDEX_W-1:0]   hostBlockAddr;

    dataCache u_dataCache (
        .clk         (clk),
        .arstN       (arstN),
        .addr        (cpuReq.addr),
        .wdata       (cpuReq.wdata),
        .writeWord   (writeWord),
        .loadBlock   (loadBlock),
        .fillBlock   (hostRsp),
        .hit         (hit),
        .dirty       (dirty),
        .victimTag   (victimTag),
        .rdata       (rdata),
        .victimBlock (victimBlock)
    );

    dCacheController u_dCacheController (
        .clk           (clk),
        .arstN         (arstN),
        .cpuReq        (cpuReq),
        .cpuReqValid   (cpuReqValid),
        .hit           (hit),
        .dirty         (dirty),
        .victimTag     (victimTag),
        .hostAck       (hostAck),
        .cpuAck        (cpuAck),
        .hostReqValid  (hostReqValid),
        .hostOp        (hostOp),
        .hostBlockAddr (hostBlockAddr),
        .writeWord     (writeWord),
        .loadBlock     (loadBlock),
        .stallDma      (stallDma)
    );

    // The victim block rides along on every request, the host ignores it on a fill
    assign hostReq = '{op: hostOp, blockAddr: hostBlockAddr, wblock: victimBlock};

    // Last capture happens on the edge that raises cpuAck, so the word holds during the ack
    always_ff @(posedge clk) begin
        if (!cpuAck) begin
            cpuRsp.rdata <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/hostMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module hostMemory (
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire memPkg::hostReqT   hostReq,
    input  wire logic              hostReqValid,
    output memPkg::blockT          hostRsp,
    output logic                   hostAck
);

    import memPkg::*;

    localparam int hostIdxW = $clog2(`HOST_BLOCKS);

    blockT                memArr [`HOST_BLOCKS];
    logic [hostIdxW-1:0]  blockIdx;
    logic                 seenReq;
    logic                 serve;

    // Only the low block address bits select a block, the rest wraps around
    assign blockIdx = hostReq.blockAddr[hostIdxW-1:0];

    // First cycle a request is seen, so each request touches memory once
    assign serve = hostReqValid && !seenReq;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            seenReq <= 1'b0;
            hostAck <= 1'b0;
        end else begin
            seenReq <= hostReqValid;
            // Ack comes one cycle after the request is seen and drops with it
            hostAck <= hostReqValid && seenReq;
        end
    end

    always_ff @(posedge clk) begin
        if (serve) begin
            if (hostReq.op == HOST_WRITEBACK) begin
                memArr[blockIdx] <= hostReq.wblock;
            end else begin
                hostRsp <= memArr[blockIdx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire memPkg::cpuReqT   cpuReq,
    input  wire logic             cpuReqValid,
    output wire memPkg::cpuRspT   cpuRsp,
    output wire logic             cpuAck,
    output wire logic             stallDma
);

    import memPkg::*;

    wire hostReqT  hostReq;
    wire logic     hostReqValid;
    wire blockT    hostRsp;
    wire logic     hostAck;

    memoryStage u_memoryStage (
        .clk          (clk),
        .arstN        (arstN),
        .cpuReq       (cpuReq),
        .cpuReqValid  (cpuReqValid),
        .hostRsp      (hostRsp),
        .hostAck      (hostAck),
        .cpuRsp       (cpuRsp),
        .cpuAck       (cpuAck),
        .hostReq      (hostReq),
        .hostReqValid (hostReqValid),
        .stallDma     (stallDma)
    );

    hostMemory u_hostMemory (
        .clk          (clk),
        .arstN        (arstN),
        .hostReq      (hostReq),
        .hostReqValid (hostReqValid),
        .hostRsp      (hostRsp),
        .hostAck      (hostAck)
    );

endmodule

`default_nettype wire

// ==== tb/memSubsystem_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemAssertions (
    input wire logic            clk,
    input wire logic            arstN,
    input wire memPkg::cpuReqT  cpuReq,
    input wire logic            cpuReqValid,
    input wire logic            cpuAck,
    input wire logic            hostReqValid,
    input wire logic            hostAck,
    input wire logic            stallDma
);

    // Number of failed assertions, read by the testbench for its verdict
    int assertFails = 0;

    // A pending request keeps its valid and its contents until the stage answers
    reqHeld: assert property (@(posedge clk) disable iff (!arstN)
        (cpuReqValid && !cpuAck) |=> cpuReqValid)
        else begin
            assertFails++;
            $error("cpuReqValid dropped before cpuAck");
        end

    reqStable: assert property (@(posedge clk) disable iff (!arstN)
        (cpuReqValid && !cpuAck) |=> $stable(cpuReq))
        else begin
            assertFails++;
            $error("cpuReq changed while the request was pending");
        end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(cpuAck) |-> cpuReqValid)
        else begin
            assertFails++;
            $error("cpuAck rose without a request");
        end

    // The ack may take a cycle to drop, so the stall can trail it by one cycle
    stallOnlyForHost: assert property (@(posedge clk) disable iff (!arstN)
        stallDma |-> (hostReqValid || hostAck || $past(hostAck)))
        else begin
            assertFails++;
            $error("stallDma high with no host transfer");
        end

    // The host memory answers only a request that is still raised
    hostAckNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(hostAck) |-> hostReqValid)
        else begin
            assertFails++;
            $error("hostAck rose without a host request");
        end

endmodule

bind memoryStage memSubsystemAssertions u_memSubsystemAssertions (
    .clk          (clk),
    .arstN        (arstN),
    .cpuReq       (cpuReq),
    .cpuReqValid  (cpuReqValid),
    .cpuAck       (cpuAck),
    .hostReqValid (hostReqValid),
    .hostAck      (hostAck),
    .stallDma     (stallDma)
);

`default_nettype wire

// ==== tb/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module memSubsystemTb;

    import memPkg::*;

    localparam int maxCycles = 20000;
    localparam int hitLatency = 2;

    logic   clk;
    logic   arstN;
    cpuReqT cpuReq;
    logic   cpuReqValid;
    cpuRspT cpuRsp;
    logic   cpuAck;
    logic   stallDma;

    int errCount;
    int checkCount;
    int cycleCount;
    int assertErrs;

    // Reference memory, keyed by word position inside the wrapped host space
    logic [`ADDR_W-1:0] refMem [int];

    memSubsystem u_memSubsystem (
        .clk         (clk),
        .arstN       (arstN),
        .cpuReq      (cpuReq),
        .cpuReqValid (cpuReqValid),
        .cpuRsp      (cpuRsp),
        .cpuAck      (cpuAck),
        .stallDma    (stallDma)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", maxCycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic checkRsp(input string name, input cpuRspT got, input cpuRspT exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t %s got %h expected %h", $time, name, got.rdata, exp.rdata);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errCount++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic memAddrT makeAddr(input logic [`TAG_W-1:0] tag,
                                         input logic [`INDEX_W-1:0] index,
                                         input logic [`OFFSET_W-3:0] word);
        memAddrT a;
        a.f.tag     = tag;
        a.f.index   = index;
        a.f.wordSel = word;
        a.f.byteOff = 2'b00;
        return a;
    endfunction

    // Block addresses beyond the host depth fold back onto the same host block
    function automatic int refKey(input memAddrT a);
        int blockNum;
        blockNum = {a.f.tag, a.f.index} % `HOST_BLOCKS;
        return blockNum * (`BLOCK_BITS / `ADDR_W) + a.f.wordSel;
    endfunction

    // One full four-phase access; latency counts edges after the sampling edge
    task automatic doAccess(input logic isWrite, input memAddrT a, input logic [`ADDR_W-1:0] wd,
                            input int hold, output cpuRspT rsp, output int latency,
                            output logic stalled);
        int edges;
        edges   = 0;
        stalled = 1'b0;
        @(posedge clk);
        #0.5;
        cpuReq.read  = !isWrite;
        cpuReq.write = isWrite;
        cpuReq.addr  = a;
        cpuReq.wdata = wd;
        cpuReqValid  = 1'b1;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (stallDma) begin
                stalled = 1'b1;
            end
        end while (!cpuAck);
        rsp     = cpuRsp;
        latency = edges - 1;
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            checkBit("cpuAck", cpuAck, 1'b1);
            checkBit("stallDma", stallDma, 1'b0);
            checkRsp("cpuRsp", cpuRsp, rsp);
        end
        @(posedge clk);
        #0.5;
        cpuReqValid = 1'b0;
        do begin
            @(posedge clk);
            @(negedge clk);
        end while (cpuAck);
    endtask

    task automatic storeWord(input memAddrT a, input logic [`ADDR_W-1:0] d);
        cpuRspT rsp;
        int     lat;
        logic   st;
        doAccess(1'b1, a, d, 0, rsp, lat, st);
        refMem[refKey(a)] = d;
    endtask

    // Words never written hold unknown host data, so only known words are compared
    task automatic loadAndCheck(input memAddrT a, input int hold, output int lat,
                                output logic st);
        cpuRspT rsp;
        cpuRspT exp;
        doAccess(1'b0, a, '0, hold, rsp, lat, st);
        if (refMem.exists(refKey(a))) begin
            exp.rdata = refMem[refKey(a)];
            checkRsp("cpuRsp.rdata", rsp, exp);
        end
    endtask

    task automatic resetState();
        int   lat;
        logic st;
        checkBit("cpuAck", cpuAck, 1'b0);
        checkBit("stallDma", stallDma, 1'b0);
        for (int k = 0; k < 3; k++) begin
            loadAndCheck(makeAddr(22'(22'h00200 + k), 4'(k * 5), 4'(k)), 0, lat, st);
            checkBit("stallDma before cpuAck", st, 1'b1);
        end
    endtask

    task automatic storeThenLoad();
        int   lat;
        logic st;
        storeWord(makeAddr(22'h00310, 4'd1, 4'd3), 32'hC0DE_0001);
        loadAndCheck(makeAddr(22'h00310, 4'd1, 4'd3), 0, lat, st);
        checkBit("stallDma on hit", st, 1'b0);
        checkLatency("hit latency", lat, hitLatency);
        loadAndCheck(makeAddr(22'h00310, 4'd1, 4'd9), 0, lat, st);
        checkBit("stallDma on same block", st, 1'b0);
        checkLatency("same block latency", lat, hitLatency);
    endtask

    task automatic cleanRefill();
        int   lat;
        logic st;
        storeWord(makeAddr(22'h00501, 4'd3, 4'd0), 32'h1111_AAAA);
        storeWord(makeAddr(22'h00501, 4'd3, 4'd7), 32'h2222_BBBB);
        // Pushes the dirty block out and leaves a clean line behind
        loadAndCheck(makeAddr(22'h00502, 4'd3, 4'd4), 0, lat, st);
        loadAndCheck(makeAddr(22'h00501, 4'd3, 4'd7), 0, lat, st);
        checkBit("stallDma on clean miss", st, 1'b1);
        loadAndCheck(makeAddr(22'h00501, 4'd3, 4'd0), 0, lat, st);
    endtask

    task automatic conflictEviction();
        int   lat;
        logic st;
        storeWord(makeAddr(22'h00401, 4'd6, 4'd2), 32'hAAAA_0401);
        storeWord(makeAddr(22'h00402, 4'd6, 4'd2), 32'hBBBB_0402);
        loadAndCheck(makeAddr(22'h00401, 4'd6, 4'd2), 0, lat, st);
        checkBit("stallDma on conflict miss", st, 1'b1);
        loadAndCheck(makeAddr(22'h00402, 4'd6, 4'd2), 0, lat, st);
    endtask

    task automatic randomTraffic();
        memAddrT a;
        int      lat;
        logic    st;
        for (int i = 0; i < 200; i++) begin
            a = makeAddr(22'(22'h01000 + ($urandom % 8) * 7),
                         4'(2 + ($urandom % 4) * 3),
                         4'($urandom % 16));
            if ($urandom % 2) begin
                storeWord(a, $urandom);
            end else begin
                loadAndCheck(a, 0, lat, st);
            end
        end
    endtask

    task automatic heldHandshake();
        int   lat;
        logic st;
        storeWord(makeAddr(22'h00310, 4'd1, 4'd5), 32'h5A5A_0005);
        loadAndCheck(makeAddr(22'h00310, 4'd1, 4'd5), 5, lat, st);
        loadAndCheck(makeAddr(22'h00310, 4'd1, 4'd5), 0, lat, st);
        checkLatency("latency after held ack", lat, hitLatency);
    endtask

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        cpuReqValid = 1'b0;
        cpuReq      = '0;
        errCount    = 0;
        checkCount  = 0;
        cycleCount  = 0;
        assertErrs  = 0;
        void'($urandom(43701));
        repeat (4) @(posedge clk);
        #0.5;
        arstN = 1'b1;
        @(negedge clk);
        resetState();
        storeThenLoad();
        cleanRefill();
        conflictEviction();
        randomTraffic();
        heldHandshake();
        assertErrs = u_memSubsystem.u_memoryStage.u_memSubsystemAssertions.assertFails;
        $display("Checks: %0d  Errors: %0d  Assertion failures: %0d",
                 checkCount, errCount, assertErrs);
        if (errCount == 0 && assertErrs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/memPkg.sv
memoryStage/dataCache.sv
memoryStage/dCacheController.sv
memoryStage/memoryStage.sv
design/hostMemory.sv
design/memSubsystem.sv
tb/memSubsystem_assertions.sv
tb/memSubsystemTb.sv
